//--- verification/periph_trace.txt
# op addr data exp_rdata exp_resp exp_pins, all hex
# op 0 write, 1 read, 2 drive gpio_i, 3 hold data cycles; pins {cluster, pwm, gpio_oe, gpio_o}
1 004 00000000 0A150001 0 0000000000
0 000 00000005 00000000 0 5000000000
1 000 00000000 00000005 0 5000000000
0 004 12345678 00000000 0 5000000000
1 004 00000000 0A150001 0 5000000000
0 100 0000A5C3 00000000 0 500000A5C3
0 104 0000FF0F 00000000 0 50FF0FA5C3
1 100 00000000 0000A5C3 0 50FF0FA5C3
1 104 00000000 0000FF0F 0 50FF0FA5C3
1 108 00000000 00000000 0 50FF0FA5C3
2 000 00003C96 00000000 0 50FF0FA5C3
1 108 00000000 00003C96 0 50FF0FA5C3
1 20C 00000000 00000000 0 50FF0FA5C3
0 204 00000003 00000000 0 50FF0FA5C3
0 200 00000001 00000000 0 50FF0FA5C3
3 000 0000000C 00000000 0 50FF0FA5C3
0 208 00000005 00000000 0 51FF0FA5C3
3 000 0000000C 00000000 0 51FF0FA5C3
1 200 00000000 00000001 0 51FF0FA5C3
1 208 00000000 00000005 0 51FF0FA5C3
1 308 00000000 00000000 0 51FF0FA5C3
1 30C 00000000 00000000 0 51FF0FA5C3
0 900 FFFFFFFF 00000000 2 51FF0FA5C3
1 904 00000000 00000000 2 51FF0FA5C3
1 F00 00000000 00000000 2 51FF0FA5C3
0 000 FFFFFFFA 00000000 0 21FF0FA5C3
1 000 00000000 FFFFFFFA 0 21FF0FA5C3
3 000 00000008 00000000 0 21FF0FA5C3

//--- project.f
hw/periph_pkg.sv
hw/axil_periph_bridge.sv
hw/periph_decoder.sv
hw/periph_read_mux.sv
hw/pwm_channel.sv
hw/gpio_port.sv
hw/soc_control.sv
hw/apb_subsystem.sv
verification/tb_apb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_apb_subsystem -f project.f -o sim_tb
output=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi

//--- verification/tb_apb_subsystem.sv
`timescale 1ns/1ns

module tb_apb_subsystem;

   localparam int MAX_OPS = 64;

   logic                                clk;
   logic                                rst_n;
   logic [periph_pkg::ADDR_W-1:0]       s_awaddr_i;
   logic                                s_awvalid_i;
   logic                                s_awready_o;
   logic [periph_pkg::DATA_W-1:0]       s_wdata_i;
   logic [periph_pkg::DATA_W/8-1:0]     s_wstrb_i;
   logic                                s_wvalid_i;
   logic                                s_wready_o;
   logic [1:0]                          s_bresp_o;
   logic                                s_bvalid_o;
   logic                                s_bready_i;
   logic [periph_pkg::ADDR_W-1:0]       s_araddr_i;
   logic                                s_arvalid_i;
   logic                                s_arready_o;
   logic [periph_pkg::DATA_W-1:0]       s_rdata_o;
   logic [1:0]                          s_rresp_o;
   logic                                s_rvalid_o;
   logic                                s_rready_i;
   logic [periph_pkg::NUM_GPIO-1:0]     gpio_in;
   logic [periph_pkg::NUM_GPIO-1:0]     gpio_out;
   logic [periph_pkg::NUM_GPIO-1:0]     gpio_oe;
   logic [periph_pkg::NUM_PWM-1:0]      pwm;
   logic                                cluster_rstn;
   logic                                cluster_en_sa_boot;
   logic                                cluster_fetch_en;
   logic [63:0]                         pins;

   // Trace columns with one entry per access
   logic [63:0] op_t       [MAX_OPS];
   logic [63:0] addr_t     [MAX_OPS];
   logic [63:0] data_t     [MAX_OPS];
   logic [63:0] rdata_t    [MAX_OPS];
   logic [63:0] resp_t     [MAX_OPS];
   logic [63:0] pins_t     [MAX_OPS];
   int          n_ops;
   bit          trace_loaded = 1'b0;

   // Same packing as the pin column of the trace
   assign pins = {25'd0, cluster_fetch_en, cluster_en_sa_boot, cluster_rstn,
                  pwm, gpio_oe, gpio_out};

   apb_subsystem apb_subsystem_inst (
      .clk_i                ( clk                ),
      .rst_n_i              ( rst_n              ),
      .s_awaddr_i           ( s_awaddr_i         ),
      .s_awvalid_i          ( s_awvalid_i        ),
      .s_awready_o          ( s_awready_o        ),
      .s_wdata_i            ( s_wdata_i          ),
      .s_wstrb_i            ( s_wstrb_i          ),
      .s_wvalid_i           ( s_wvalid_i         ),
      .s_wready_o           ( s_wready_o         ),
      .s_bresp_o            ( s_bresp_o          ),
      .s_bvalid_o           ( s_bvalid_o         ),
      .s_bready_i           ( s_bready_i         ),
      .s_araddr_i           ( s_araddr_i         ),
      .s_arvalid_i          ( s_arvalid_i        ),
      .s_arready_o          ( s_arready_o        ),
      .s_rdata_o            ( s_rdata_o          ),
      .s_rresp_o            ( s_rresp_o          ),
      .s_rvalid_o           ( s_rvalid_o         ),
      .s_rready_i           ( s_rready_i         ),
      .gpio_i               ( gpio_in            ),
      .gpio_o               ( gpio_out           ),
      .gpio_oe_o            ( gpio_oe            ),
      .pwm_o                ( pwm                ),
      .cluster_rstn_o       ( cluster_rstn       ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot ),
      .cluster_fetch_en_o   ( cluster_fetch_en   )
   );

   always #10 clk = ~clk;

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   // Response waits a random number of cycles while new requests are offered
   task automatic hold_response(input bit is_write);
      logic [63:0] resp_seen;
      logic [63:0] data_seen;
      int unsigned delay;
      resp_seen = is_write ? s_bresp_o : s_rresp_o;
      data_seen = s_rdata_o;
      delay = $urandom % 4;
      repeat (delay) begin
         s_awvalid_i = 1'b1;
         s_wvalid_i  = 1'b1;
         s_arvalid_i = 1'b1;
         #1;
         check_value("awready while busy", s_awready_o, 64'd0);
         check_value("arready while busy", s_arready_o, 64'd0);
         next_cycle();
         check_value("valid held", is_write ? s_bvalid_o : s_rvalid_o, 64'd1);
         check_value("resp held", is_write ? s_bresp_o : s_rresp_o, resp_seen);
         if (!is_write) begin
            check_value("rdata held", s_rdata_o, data_seen);
         end
      end
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      s_arvalid_i = 1'b0;
      s_bready_i  = is_write;
      s_rready_i  = !is_write;
      next_cycle();
      s_bready_i = 1'b0;
      s_rready_i = 1'b0;
      check_value("valid after accept", is_write ? s_bvalid_o : s_rvalid_o, 64'd0);
   endtask

   task automatic write_access(input logic [63:0] addr, input logic [63:0] data,
                               input logic [63:0] exp_resp);
      logic hs;
      s_awaddr_i  = addr[periph_pkg::ADDR_W-1:0];
      s_wdata_i   = data[periph_pkg::DATA_W-1:0];
      s_awvalid_i = 1'b1;
      s_wvalid_i  = 1'b1;
      hs = 1'b0;
      while (!hs) begin
         #1;
         hs = s_awready_o && s_wready_o;
         next_cycle();
      end
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
      while (!s_bvalid_o) begin
         next_cycle();
      end
      check_value("bresp", s_bresp_o, exp_resp);
      hold_response(1'b1);
   endtask

   task automatic read_access(input logic [63:0] addr, input logic [63:0] exp_rdata,
                              input logic [63:0] exp_resp);
      logic hs;
      s_araddr_i  = addr[periph_pkg::ADDR_W-1:0];
      s_arvalid_i = 1'b1;
      hs = 1'b0;
      while (!hs) begin
         #1;
         hs = s_arready_o;
         next_cycle();
      end
      s_arvalid_i = 1'b0;
      while (!s_rvalid_o) begin
         next_cycle();
      end
      check_value("rresp", s_rresp_o, exp_resp);
      check_value("rdata", s_rdata_o, exp_rdata);
      hold_response(1'b0);
   endtask

   initial begin
      int          fd;
      int          fields;
      string       line;
      logic [63:0] f_op;
      logic [63:0] f_addr;
      logic [63:0] f_data;
      logic [63:0] f_rdata;
      logic [63:0] f_resp;
      logic [63:0] f_pins;
      void'($urandom(32'h71e8_0711));
      clk         = 1'b0;
      rst_n       = 1'b0;
      s_awaddr_i  = '0;
      s_awvalid_i = 1'b0;
      s_wdata_i   = '0;
      s_wstrb_i   = '1;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b0;
      s_araddr_i  = '0;
      s_arvalid_i = 1'b0;
      s_rready_i  = 1'b0;
      gpio_in     = '0;

      fd = $fopen("verification/periph_trace.txt", "r");
      if (fd == 0) begin
         $display("The trace file verification/periph_trace.txt could not be opened");
         $display("Done: errors found");
         $fatal(1);
      end
      n_ops = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line.getc(0) != "#") begin
            fields = $sscanf(line, "%h %h %h %h %h %h",
                             f_op, f_addr, f_data, f_rdata, f_resp, f_pins);
            if (fields != 6) begin
               $display("Trace line %0d does not have six hex columns", n_ops);
               $display("Done: errors found");
               $fatal(1);
            end
            op_t[n_ops]    = f_op;
            addr_t[n_ops]  = f_addr;
            data_t[n_ops]  = f_data;
            rdata_t[n_ops] = f_rdata;
            resp_t[n_ops]  = f_resp;
            pins_t[n_ops]  = f_pins;
            n_ops++;
         end
      end
      $fclose(fd);
      trace_loaded = 1'b1;

      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value("pins after reset", pins, 64'd0);
      check_value("bvalid after reset", s_bvalid_o, 64'd0);
      check_value("rvalid after reset", s_rvalid_o, 64'd0);

      for (int i = 0; i < n_ops; i++) begin
         case (op_t[i])
            64'd0: write_access(addr_t[i], data_t[i], resp_t[i]);
            64'd1: read_access(addr_t[i], rdata_t[i], resp_t[i]);
            64'd2: begin
               gpio_in = data_t[i][periph_pkg::NUM_GPIO-1:0];
               repeat (3) next_cycle();
            end
            64'd3: begin
               repeat (data_t[i]) begin
                  check_value($sformatf("pins during op %0d", i), pins, pins_t[i]);
                  next_cycle();
               end
            end
            default: begin
               $display("Trace line %0d has an unknown operation code", i);
               $display("Done: errors found");
               $fatal(1);
            end
         endcase
         check_value($sformatf("pins after op %0d", i), pins, pins_t[i]);
      end

      $display("Done: no errors");
      $finish;
   end

   // Watchdog scaled to the trace length
   initial begin
      wait (trace_loaded);
      repeat (n_ops * 50) @(posedge clk);
      $display("Timeout: the trace did not finish within %0d cycles", n_ops * 50);
      $display("Done: errors found");
      $fatal(1);
   end

endmodule

//--- hw/apb_subsystem.sv
`timescale 1ns/1ns

module apb_subsystem (
   input  logic                              clk_i,
   input  logic                              rst_n_i,

   input  logic [periph_pkg::ADDR_W-1:0]     s_awaddr_i,
   input  logic                              s_awvalid_i,
   output logic                              s_awready_o,
   input  logic [periph_pkg::DATA_W-1:0]     s_wdata_i,
   input  logic [periph_pkg::DATA_W/8-1:0]   s_wstrb_i,
   input  logic                              s_wvalid_i,
   output logic                              s_wready_o,
   output logic [1:0]                        s_bresp_o,
   output logic                              s_bvalid_o,
   input  logic                              s_bready_i,
   input  logic [periph_pkg::ADDR_W-1:0]     s_araddr_i,
   input  logic                              s_arvalid_i,
   output logic                              s_arready_o,
   output logic [periph_pkg::DATA_W-1:0]     s_rdata_o,
   output logic [1:0]                        s_rresp_o,
   output logic                              s_rvalid_o,
   input  logic                              s_rready_i,

   input  logic [periph_pkg::NUM_GPIO-1:0]   gpio_i,
   output logic [periph_pkg::NUM_GPIO-1:0]   gpio_o,
   output logic [periph_pkg::NUM_GPIO-1:0]   gpio_oe_o,
   output logic [periph_pkg::NUM_PWM-1:0]    pwm_o,
   output logic                              cluster_rstn_o,
   output logic                              cluster_en_sa_boot_o,
   output logic                              cluster_fetch_en_o
);

   logic                               req;
   logic                               we;
   logic [periph_pkg::ADDR_W-1:0]      addr;
   logic [periph_pkg::DATA_W-1:0]      wdata;
   logic [periph_pkg::DATA_W-1:0]      rdata;
   logic                               err;
   logic [periph_pkg::NUM_SLOTS-1:0]   sel;
   logic [periph_pkg::REG_W-1:0]       reg_idx;
   logic [periph_pkg::DATA_W-1:0]      slot_rdata [periph_pkg::NUM_SLOTS];

   assign reg_idx = addr[periph_pkg::REG_LSB +: periph_pkg::REG_W];

   axil_periph_bridge i_axil_periph_bridge (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .s_awaddr_i  ( s_awaddr_i  ),
      .s_awvalid_i ( s_awvalid_i ),
      .s_awready_o ( s_awready_o ),
      .s_wdata_i   ( s_wdata_i   ),
      .s_wstrb_i   ( s_wstrb_i   ),
      .s_wvalid_i  ( s_wvalid_i  ),
      .s_wready_o  ( s_wready_o  ),
      .s_bresp_o   ( s_bresp_o   ),
      .s_bvalid_o  ( s_bvalid_o  ),
      .s_bready_i  ( s_bready_i  ),
      .s_araddr_i  ( s_araddr_i  ),
      .s_arvalid_i ( s_arvalid_i ),
      .s_arready_o ( s_arready_o ),
      .s_rdata_o   ( s_rdata_o   ),
      .s_rresp_o   ( s_rresp_o   ),
      .s_rvalid_o  ( s_rvalid_o  ),
      .s_rready_i  ( s_rready_i  ),
      .req_o       ( req         ),
      .we_o        ( we          ),
      .addr_o      ( addr        ),
      .wdata_o     ( wdata       ),
      .rdata_i     ( rdata       ),
      .err_i       ( err         )
   );

   periph_decoder i_periph_decoder (
      .req_i      ( req  ),
      .addr_i     ( addr ),
      .sel_o      ( sel  ),
      .unmapped_o (      )
   );

   soc_control i_soc_control (
      .clk_i                ( clk_i                                ),
      .rst_n_i              ( rst_n_i                              ),
      .sel_i                ( sel[periph_pkg::SLOT_SOCCTRL]        ),
      .we_i                 ( we                                   ),
      .reg_i                ( reg_idx                              ),
      .wdata_i              ( wdata                                ),
      .rdata_o              ( slot_rdata[periph_pkg::SLOT_SOCCTRL] ),
      .cluster_rstn_o       ( cluster_rstn_o                       ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot_o                 ),
      .cluster_fetch_en_o   ( cluster_fetch_en_o                   )
   );

   gpio_port i_gpio_port (
      .clk_i     ( clk_i                             ),
      .rst_n_i   ( rst_n_i                           ),
      .sel_i     ( sel[periph_pkg::SLOT_GPIO]        ),
      .we_i      ( we                                ),
      .reg_i     ( reg_idx                           ),
      .wdata_i   ( wdata                             ),
      .gpio_i    ( gpio_i                            ),
      .rdata_o   ( slot_rdata[periph_pkg::SLOT_GPIO] ),
      .gpio_o    ( gpio_o                            ),
      .gpio_oe_o ( gpio_oe_o                         )
   );

   // PWM channel k sits in slot SLOT_PWM0 + k
   for (genvar k = 0; k < periph_pkg::NUM_PWM; k++) begin : g_pwm
      pwm_channel i_pwm_channel (
         .clk_i   ( clk_i                               ),
         .rst_n_i ( rst_n_i                             ),
         .sel_i   ( sel[periph_pkg::SLOT_PWM0 + k]      ),
         .we_i    ( we                                  ),
         .reg_i   ( reg_idx                             ),
         .wdata_i ( wdata                               ),
         .rdata_o ( slot_rdata[periph_pkg::SLOT_PWM0 + k] ),
         .pwm_o   ( pwm_o[k]                            )
      );
   end

   for (genvar s = periph_pkg::SLOT_LAST + 1; s < periph_pkg::NUM_SLOTS; s++) begin : g_empty
      assign slot_rdata[s] = '0;
   end

   periph_read_mux i_periph_read_mux (
      .addr_i       ( addr       ),
      .slot_rdata_i ( slot_rdata ),
      .rdata_o      ( rdata      ),
      .err_o        ( err        )
   );

endmodule

//--- hw/soc_control.sv
`timescale 1ns/1ns

module soc_control (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            sel_i,
   input  logic                            we_i,
   input  logic [periph_pkg::REG_W-1:0]    reg_i,
   input  logic [periph_pkg::DATA_W-1:0]   wdata_i,
   output logic [periph_pkg::DATA_W-1:0]   rdata_o,
   output logic                            cluster_rstn_o,
   output logic                            cluster_en_sa_boot_o,
   output logic                            cluster_fetch_en_o
);

   logic [periph_pkg::DATA_W-1:0] ctrl_q;

   // Only the control register is writable, the ID register is constant
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (sel_i && we_i && reg_i == periph_pkg::SOC_CTRL_REG) begin
         ctrl_q <= wdata_i;
      end
   end

   // Cluster stays in reset until software releases it
   assign cluster_rstn_o       = ctrl_q[0];
   assign cluster_en_sa_boot_o = ctrl_q[1];
   assign cluster_fetch_en_o   = ctrl_q[2];

   always_comb begin
      case (reg_i)
         periph_pkg::SOC_CTRL_REG: rdata_o = ctrl_q;
         periph_pkg::SOC_ID_REG:   rdata_o = periph_pkg::SOC_ID;
         default:                  rdata_o = '0;
      endcase
   end

endmodule

//--- hw/gpio_port.sv
`timescale 1ns/1ns

module gpio_port (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              sel_i,
   input  logic                              we_i,
   input  logic [periph_pkg::REG_W-1:0]      reg_i,
   input  logic [periph_pkg::DATA_W-1:0]     wdata_i,
   input  logic [periph_pkg::NUM_GPIO-1:0]   gpio_i,
   output logic [periph_pkg::DATA_W-1:0]     rdata_o,
   output logic [periph_pkg::NUM_GPIO-1:0]   gpio_o,
   output logic [periph_pkg::NUM_GPIO-1:0]   gpio_oe_o
);

   localparam int unsigned PAD_W = periph_pkg::DATA_W - periph_pkg::NUM_GPIO;

   logic [periph_pkg::NUM_GPIO-1:0] out_q;
   logic [periph_pkg::NUM_GPIO-1:0] dir_q;
   logic [periph_pkg::NUM_GPIO-1:0] in_meta_q;
   logic [periph_pkg::NUM_GPIO-1:0] in_sync_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_q <= '0;
         dir_q <= '0;
      end else if (sel_i && we_i) begin
         case (reg_i)
            periph_pkg::GPIO_OUT_REG: out_q <= wdata_i[periph_pkg::NUM_GPIO-1:0];
            periph_pkg::GPIO_DIR_REG: dir_q <= wdata_i[periph_pkg::NUM_GPIO-1:0];
            default: ;
         endcase
      end
   end

   // Two-stage input synchronizer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         in_meta_q <= '0;
         in_sync_q <= '0;
      end else begin
         in_meta_q <= gpio_i;
         in_sync_q <= in_meta_q;
      end
   end

   assign gpio_o    = out_q;
   assign gpio_oe_o = dir_q;

   always_comb begin
      case (reg_i)
         periph_pkg::GPIO_OUT_REG: rdata_o = {{PAD_W{1'b0}}, out_q};
         periph_pkg::GPIO_DIR_REG: rdata_o = {{PAD_W{1'b0}}, dir_q};
         periph_pkg::GPIO_IN_REG:  rdata_o = {{PAD_W{1'b0}}, in_sync_q};
         default:                  rdata_o = '0;
      endcase
   end

endmodule

//--- hw/pwm_channel.sv
`timescale 1ns/1ns

module pwm_channel (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            sel_i,
   input  logic                            we_i,
   input  logic [periph_pkg::REG_W-1:0]    reg_i,
   input  logic [periph_pkg::DATA_W-1:0]   wdata_i,
   output logic [periph_pkg::DATA_W-1:0]   rdata_o,
   output logic                            pwm_o
);

   logic                            en_q;
   logic [periph_pkg::DATA_W-1:0]   period_q;
   logic [periph_pkg::DATA_W-1:0]   duty_q;
   logic [periph_pkg::DATA_W-1:0]   count_q;
   logic                            wr;

   assign wr = sel_i && we_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         duty_q   <= '0;
      end else if (wr) begin
         case (reg_i)
            periph_pkg::PWM_CTRL_REG:   en_q     <= wdata_i[0];
            periph_pkg::PWM_PERIOD_REG: period_q <= wdata_i;
            periph_pkg::PWM_DUTY_REG:   duty_q   <= wdata_i;
            default: ;
         endcase
      end
   end

   // Counts 0..period inclusive, then wraps; held at zero while disabled
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (!en_q || count_q >= period_q) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 1'b1;
      end
   end

   assign pwm_o = en_q && (count_q < duty_q);

   always_comb begin
      case (reg_i)
         periph_pkg::PWM_CTRL_REG:   rdata_o = {{(periph_pkg::DATA_W-1){1'b0}}, en_q};
         periph_pkg::PWM_PERIOD_REG: rdata_o = period_q;
         periph_pkg::PWM_DUTY_REG:   rdata_o = duty_q;
         default:                    rdata_o = count_q;
      endcase
   end

endmodule

//--- hw/periph_read_mux.sv
`timescale 1ns/1ns

module periph_read_mux (
   input  logic [periph_pkg::ADDR_W-1:0]   addr_i,
   input  logic [periph_pkg::DATA_W-1:0]   slot_rdata_i [periph_pkg::NUM_SLOTS],
   output logic [periph_pkg::DATA_W-1:0]   rdata_o,
   output logic                            err_o
);

   logic [periph_pkg::SLOT_W-1:0] slot;

   assign slot = addr_i[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_W];

   // Slots past the last PWM channel have no peripheral behind them
   always_comb begin
      if (slot > periph_pkg::SLOT_LAST) begin
         rdata_o = '0;
         err_o   = 1'b1;
      end else begin
         rdata_o = slot_rdata_i[slot];
         err_o   = 1'b0;
      end
   end

endmodule

//--- hw/periph_decoder.sv
`timescale 1ns/1ns

module periph_decoder (
   input  logic                               req_i,
   input  logic [periph_pkg::ADDR_W-1:0]      addr_i,
   output logic [periph_pkg::NUM_SLOTS-1:0]   sel_o,
   output logic                               unmapped_o
);

   logic [periph_pkg::SLOT_W-1:0] slot;
   logic                          mapped;

   assign slot   = addr_i[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_W];
   assign mapped = (slot <= periph_pkg::SLOT_LAST);

   // One-hot select, only while a request is on the bus
   always_comb begin
      sel_o = '0;
      if (req_i && mapped) begin
         sel_o[slot] = 1'b1;
      end
   end

   assign unmapped_o = req_i && !mapped;

endmodule

//--- hw/axil_periph_bridge.sv
`timescale 1ns/1ns

module axil_periph_bridge (
   input  logic                              clk_i,
   input  logic                              rst_n_i,

   input  logic [periph_pkg::ADDR_W-1:0]     s_awaddr_i,
   input  logic                              s_awvalid_i,
   output logic                              s_awready_o,

   input  logic [periph_pkg::DATA_W-1:0]     s_wdata_i,
   input  logic [periph_pkg::DATA_W/8-1:0]   s_wstrb_i,
   input  logic                              s_wvalid_i,
   output logic                              s_wready_o,

   output logic [1:0]                        s_bresp_o,
   output logic                              s_bvalid_o,
   input  logic                              s_bready_i,

   input  logic [periph_pkg::ADDR_W-1:0]     s_araddr_i,
   input  logic                              s_arvalid_i,
   output logic                              s_arready_o,

   output logic [periph_pkg::DATA_W-1:0]     s_rdata_o,
   output logic [1:0]                        s_rresp_o,
   output logic                              s_rvalid_o,
   input  logic                              s_rready_i,

   output logic                              req_o,
   output logic                              we_o,
   output logic [periph_pkg::ADDR_W-1:0]     addr_o,
   output logic [periph_pkg::DATA_W-1:0]     wdata_o,
   input  logic [periph_pkg::DATA_W-1:0]     rdata_i,
   input  logic                              err_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRESP,
      ST_RRESP
   } state_e;

   state_e                          state_q;
   logic                            wr_hs;
   logic                            rd_hs;
   logic [1:0]                      bresp_q;
   logic [1:0]                      rresp_q;
   logic [periph_pkg::DATA_W-1:0]   rdata_q;

   // Write wins when both are offered in the same idle cycle
   assign wr_hs = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
   assign rd_hs = (state_q == ST_IDLE) && s_arvalid_i && !wr_hs;

   assign s_awready_o = wr_hs;
   assign s_wready_o  = wr_hs;
   assign s_arready_o = rd_hs;

   // Peripheral request lives only in the handshake cycle
   // (byte strobes are not supported, every write is a full word)
   assign req_o   = wr_hs || rd_hs;
   assign we_o    = wr_hs;
   assign addr_o  = wr_hs ? s_awaddr_i : s_araddr_i;
   assign wdata_o = s_wdata_i;

   assign s_bvalid_o = (state_q == ST_WRESP);
   assign s_bresp_o  = bresp_q;
   assign s_rvalid_o = (state_q == ST_RRESP);
   assign s_rresp_o  = rresp_q;
   assign s_rdata_o  = rdata_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (wr_hs) begin
                  state_q <= ST_WRESP;
               end else if (rd_hs) begin
                  state_q <= ST_RRESP;
               end
            end
            ST_WRESP: begin
               if (s_bready_i) begin
                  state_q <= ST_IDLE;
               end
            end
            ST_RRESP: begin
               if (s_rready_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Response payload, held until the master takes it
   always_ff @(posedge clk_i) begin
      if (wr_hs) begin
         bresp_q <= err_i ? periph_pkg::AXI_SLVERR : periph_pkg::AXI_OKAY;
      end
      if (rd_hs) begin
         rdata_q <= rdata_i;
         rresp_q <= err_i ? periph_pkg::AXI_SLVERR : periph_pkg::AXI_OKAY;
      end
   end

endmodule

//--- hw/periph_pkg.sv
package periph_pkg;

   // Bus widths
   localparam int unsigned ADDR_W = 12;
   localparam int unsigned DATA_W = 32;

   // Address map, 256 byte slots
   localparam int unsigned SLOT_LSB  = 8;
   localparam int unsigned SLOT_W    = 4;
   localparam int unsigned NUM_SLOTS = 16;

   localparam int unsigned SLOT_SOCCTRL = 0;
   localparam int unsigned SLOT_GPIO    = 1;
   localparam int unsigned SLOT_PWM0    = 2;
   localparam int unsigned NUM_PWM      = 4;
   localparam int unsigned SLOT_LAST    = SLOT_PWM0 + NUM_PWM - 1;

   localparam int unsigned NUM_GPIO = 16;

   // Register index within a slot, word aligned
   localparam int unsigned REG_LSB = 2;
   localparam int unsigned REG_W   = 2;

   localparam logic [REG_W-1:0] SOC_CTRL_REG = 2'd0;
   localparam logic [REG_W-1:0] SOC_ID_REG   = 2'd1;

   localparam logic [REG_W-1:0] GPIO_OUT_REG = 2'd0;
   localparam logic [REG_W-1:0] GPIO_DIR_REG = 2'd1;
   localparam logic [REG_W-1:0] GPIO_IN_REG  = 2'd2;

   localparam logic [REG_W-1:0] PWM_CTRL_REG   = 2'd0;
   localparam logic [REG_W-1:0] PWM_PERIOD_REG = 2'd1;
   localparam logic [REG_W-1:0] PWM_DUTY_REG   = 2'd2;
   localparam logic [REG_W-1:0] PWM_COUNT_REG  = 2'd3;

   localparam logic [DATA_W-1:0] SOC_ID = 32'h0A15_0001;

   // AXI response codes
   localparam logic [1:0] AXI_OKAY   = 2'b00;
   localparam logic [1:0] AXI_SLVERR = 2'b10;

endpackage
